// File: logic/alu_config.svh
// --------------------------------------------------
// ALU cluster sizing, included by the package and RTL
// --------------------------------------------------
`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

// lanes working in parallel
`define ALU_LANES  4

// operand and result width
`define ALU_DATA_W 32

// shift step counter, holds 1..16
`define ALU_CNT_W  5

`endif

// File: logic/alu_pkg.sv
// --------------------------------------------------
// shared types of the ALU cluster: operations, widths,
// flags and the request and response words
// --------------------------------------------------
`include "alu_config.svh"

package alu_pkg;

    typedef logic [`ALU_DATA_W-1:0] alu_data_t;

    typedef enum logic [4:0] {
        OP_ADD,
        OP_ADC,
        OP_SUB,
        OP_SBC,
        OP_CP,   // compare, data returns operand a
        OP_NEG,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_RL,   // rotate through carry
        OP_RR,
        OP_RLC,  // rotate within width
        OP_RRC,
        OP_SLA,
        OP_SRA,
        OP_SLL,
        OP_SRL
    } alu_op_t;

    typedef enum logic [1:0] {
        W8,
        W16,
        W32
    } alu_width_t;

    typedef struct packed {
        logic s;
        logic z;
        logic h;
        logic v;  // overflow or even parity
        logic n;
        logic c;
    } alu_flags_t;

    typedef struct packed {
        alu_op_t    op;
        alu_width_t width;
        alu_data_t  a;
        alu_data_t  b;     // shift count in b[3:0]
        logic       carry;
    } alu_req_t;

    typedef struct packed {
        alu_data_t  data;
        alu_flags_t flags;
    } alu_rsp_t;

    typedef logic [$clog2(`ALU_LANES)-1:0] lane_idx_t;

    // round robin step shared by dispatcher and collector
    function automatic lane_idx_t next_lane(lane_idx_t idx);
        return (idx == lane_idx_t'(`ALU_LANES - 1)) ? '0 : idx + 1'b1;
    endfunction

endpackage

// File: logic/lane_if.sv
// --------------------------------------------------
// request and response channels of one lane, shared
// by the dispatcher, the lane and the collector
// --------------------------------------------------
`timescale 1ns/1ps

interface lane_if import alu_pkg::*; ();

    logic     req_valid;
    logic     req_ready;
    alu_req_t req;
    logic     rsp_valid;
    logic     rsp_ready;
    alu_rsp_t rsp;

    modport dispatch (
        output req_valid,
        output req,
        input  req_ready
    );

    modport lane (
        input  req_valid,
        input  req,
        output req_ready,
        output rsp_valid,
        output rsp,
        input  rsp_ready
    );

    modport collect (
        input  rsp_valid,
        input  rsp,
        output rsp_ready
    );

endinterface

// File: logic/alu_dispatch.sv
// --------------------------------------------------
// steers each request to the lanes in rotating order,
// stalls while the next lane in turn is still busy
// --------------------------------------------------
`timescale 1ns/1ps
`include "alu_config.svh"

module alu_dispatch import alu_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     req_valid,
    output logic     req_ready,
    input  alu_req_t req,
    lane_if.dispatch lanes [`ALU_LANES]
);

    lane_idx_t              ptr;         // lane that takes the next request
    logic [`ALU_LANES-1:0]  lane_ready;

    for (genvar i = 0; i < `ALU_LANES; i++) begin : g_lane
        assign lanes[i].req_valid = req_valid && (ptr == lane_idx_t'(i));
        assign lanes[i].req       = req;
        assign lane_ready[i]      = lanes[i].req_ready;
    end

    assign req_ready = lane_ready[ptr];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ptr <= '0;
        end else if (req_valid && req_ready) begin
            ptr <= next_lane(ptr);  // one lane per accepted request
        end
    end

    // a waiting request keeps valid up and its payload unchanged
    a_req_hold: assert property (
        @(posedge clk) disable iff (rst)
        req_valid && !req_ready |=> req_valid && $stable(req)
    );

endmodule

// File: logic/alu_lane.sv
// --------------------------------------------------
// one ALU lane: add, subtract and logic answer in one
// cycle, shifts and rotates step one bit per cycle
// --------------------------------------------------
`timescale 1ns/1ps
`include "alu_config.svh"

module alu_lane import alu_pkg::*; (
    input  logic clk,
    input  logic rst,
    lane_if.lane port
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SHIFT,
        ST_DONE
    } state_t;

    state_t                state;
    alu_op_t               op_q;
    alu_width_t            w_q;
    alu_data_t             val_q;     // partially shifted value
    logic                  c_q;       // last bit shifted out
    logic [`ALU_CNT_W-1:0] cnt_q;     // steps still to go
    alu_rsp_t              rsp_q;

    logic                  accept;
    logic                  is_shift;
    logic                  last;
    logic                  step_en;
    logic                  finish;
    alu_op_t               sel_op;
    alu_width_t            sel_w;
    alu_data_t             sel_val;
    logic                  sel_c;
    logic [`ALU_CNT_W-1:0] cnt_load;
    logic [`ALU_CNT_W-1:0] cnt_cur;

    alu_data_t             mask;
    alu_data_t             ar_x;
    alu_data_t             ar_y;
    alu_data_t             ar_res;
    logic [`ALU_DATA_W:0]  ar_raw;
    logic [4:0]            nib;
    logic                  ar_sub;
    logic                  ar_cin;
    alu_data_t             lg_res;
    alu_data_t             sh_val;
    alu_data_t             sh_msb;
    logic                  sh_c;
    logic                  top;
    logic                  in_l;
    logic                  in_r;
    alu_rsp_t              ar_rsp;
    alu_rsp_t              lg_rsp;
    alu_rsp_t              sh_rsp;
    alu_rsp_t              res;

    function automatic alu_data_t width_mask(alu_width_t w);
        case (w)
            W8:      return alu_data_t'(8'hff);
            W16:     return alu_data_t'(16'hffff);
            default: return '1;
        endcase
    endfunction

    function automatic logic top_bit(alu_data_t v, alu_width_t w);
        case (w)
            W8:      return v[7];
            W16:     return v[15];
            default: return v[`ALU_DATA_W-1];
        endcase
    endfunction

    // S, Z and parity V of a result, the other flags cleared
    function automatic alu_flags_t result_flags(alu_data_t v, alu_width_t w);
        alu_flags_t f;
        f   = '0;
        f.s = top_bit(v, w);
        f.z = (v & width_mask(w)) == '0;
        f.v = (w == W8) ? ~^v[7:0] : ~^v[15:0];
        return f;
    endfunction

    assign accept         = port.req_valid && port.req_ready;
    assign port.req_ready = (state == ST_IDLE);
    assign port.rsp_valid = (state == ST_DONE);
    assign port.rsp       = rsp_q;

    // arithmetic, always from the incoming request
    always_comb begin
        mask   = width_mask(port.req.width);
        ar_sub = port.req.op inside {OP_SUB, OP_SBC, OP_CP, OP_NEG};
        ar_cin = (port.req.op inside {OP_ADC, OP_SBC}) && port.req.carry;
        ar_x   = (port.req.op == OP_NEG) ? '0 : port.req.a & mask;  // NEG is 0 - a
        ar_y   = (port.req.op == OP_NEG) ? port.req.a & mask : port.req.b & mask;
        if (ar_sub) begin
            ar_raw = {1'b0, ar_x} - {1'b0, ar_y} - {{`ALU_DATA_W{1'b0}}, ar_cin};
            nib    = {1'b0, ar_x[3:0]} - {1'b0, ar_y[3:0]} - {4'd0, ar_cin};
        end else begin
            ar_raw = {1'b0, ar_x} + {1'b0, ar_y} + {{`ALU_DATA_W{1'b0}}, ar_cin};
            nib    = {1'b0, ar_x[3:0]} + {1'b0, ar_y[3:0]} + {4'd0, ar_cin};
        end
        ar_res       = ar_raw[`ALU_DATA_W-1:0] & mask;
        ar_rsp.flags = result_flags(ar_res, port.req.width);
        ar_rsp.flags.h = nib[4];
        ar_rsp.flags.n = ar_sub;
        ar_rsp.flags.c = (port.req.width == W8)  ? ar_raw[8] :
                         (port.req.width == W16) ? ar_raw[16] : ar_raw[`ALU_DATA_W];
        // operands masked, so bit above the width is carry or borrow
        if (ar_sub) begin
            ar_rsp.flags.v = (top_bit(ar_x, port.req.width) != top_bit(ar_y, port.req.width))
                          && (top_bit(ar_res, port.req.width) != top_bit(ar_x, port.req.width));
        end else begin
            ar_rsp.flags.v = (top_bit(ar_x, port.req.width) == top_bit(ar_y, port.req.width))
                          && (top_bit(ar_res, port.req.width) != top_bit(ar_x, port.req.width));
        end
        ar_rsp.data = (port.req.op == OP_CP) ? port.req.a & mask : ar_res;
    end

    always_comb begin
        case (port.req.op)
            OP_AND:  lg_res = port.req.a & port.req.b;
            OP_OR:   lg_res = port.req.a | port.req.b;
            default: lg_res = port.req.a ^ port.req.b;
        endcase
        lg_rsp.data    = lg_res & mask;
        lg_rsp.flags   = result_flags(lg_rsp.data, port.req.width);
        lg_rsp.flags.h = (port.req.op == OP_AND);
    end

    // first step works on the request, later ones on the stored value
    assign sel_op   = (state == ST_IDLE) ? port.req.op : op_q;
    assign sel_w    = (state == ST_IDLE) ? port.req.width : w_q;
    assign sel_val  = (state == ST_IDLE) ? port.req.a & mask : val_q;
    assign sel_c    = (state == ST_IDLE) ? port.req.carry : c_q;
    assign cnt_load = `ALU_CNT_W'({port.req.b[3:0] == 4'd0, port.req.b[3:0]});  // 0 means 16
    assign cnt_cur  = (state == ST_SHIFT) ? cnt_q : cnt_load;
    assign is_shift = sel_op inside {OP_RL, OP_RR, OP_RLC, OP_RRC,
                                     OP_SLA, OP_SRA, OP_SLL, OP_SRL};
    assign last     = (cnt_cur == `ALU_CNT_W'(1));

    always_comb begin
        top    = top_bit(sel_val, sel_w);
        sh_msb = width_mask(sel_w) ^ (width_mask(sel_w) >> 1);
        in_l   = (sel_op == OP_RL) ? sel_c : (sel_op == OP_RLC) ? top : 1'b0;
        in_r   = (sel_op == OP_RR)  ? sel_c :
                 (sel_op == OP_RRC) ? sel_val[0] :
                 (sel_op == OP_SRA) ? top : 1'b0;
        if (sel_op inside {OP_RL, OP_RLC, OP_SLA, OP_SLL}) begin
            sh_val = {sel_val[`ALU_DATA_W-2:0], in_l} & width_mask(sel_w);
            sh_c   = top;
        end else begin
            sh_val = (sel_val >> 1) | (in_r ? sh_msb : '0);
            sh_c   = sel_val[0];
        end
        sh_rsp.data    = sh_val;
        sh_rsp.flags   = result_flags(sh_val, sel_w);
        sh_rsp.flags.c = sh_c;
    end

    assign res     = is_shift ? sh_rsp :
                     (port.req.op inside {OP_AND, OP_OR, OP_XOR}) ? lg_rsp : ar_rsp;
    assign step_en = (accept && is_shift) || (state == ST_SHIFT);
    assign finish  = (accept && !is_shift) || (step_en && last);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE:  if (accept) state <= finish ? ST_DONE : ST_SHIFT;
                ST_SHIFT: if (last) state <= ST_DONE;
                ST_DONE:  if (port.rsp_ready) state <= ST_IDLE;
                default:  state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q <= port.req.op;
            w_q  <= port.req.width;
        end
        if (step_en) begin
            val_q <= sh_val;
            c_q   <= sh_c;
            cnt_q <= cnt_cur - `ALU_CNT_W'(1);
        end
        if (finish) begin
            rsp_q <= res;
        end
    end

    a_rsp_hold: assert property (
        @(posedge clk) disable iff (rst)
        port.rsp_valid && !port.rsp_ready |=> port.rsp_valid && $stable(port.rsp)
    );

endmodule

// File: logic/alu_collect.sv
// --------------------------------------------------
// drains finished lanes in issue order onto the single
// response port of the cluster
// --------------------------------------------------
`timescale 1ns/1ps
`include "alu_config.svh"

module alu_collect import alu_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    lane_if.collect  lanes [`ALU_LANES],
    output logic     rsp_valid,
    input  logic     rsp_ready,
    output alu_rsp_t rsp
);

    lane_idx_t              ptr;           // oldest lane still owed a response
    logic [`ALU_LANES-1:0]  lane_valid;
    alu_rsp_t               lane_rsp [`ALU_LANES];

    for (genvar i = 0; i < `ALU_LANES; i++) begin : g_lane
        assign lanes[i].rsp_ready = rsp_ready && (ptr == lane_idx_t'(i));
        assign lane_valid[i]      = lanes[i].rsp_valid;
        assign lane_rsp[i]        = lanes[i].rsp;
    end

    // later lanes may finish first and wait their turn
    assign rsp_valid = lane_valid[ptr];
    assign rsp       = lane_rsp[ptr];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ptr <= '0;
        end else if (rsp_valid && rsp_ready) begin
            ptr <= next_lane(ptr);
        end
    end

    // a stalled response stays on the port unchanged until taken
    a_ptr_move: assert property (
        @(posedge clk) disable iff (rst)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp)
    );

endmodule

// File: logic/alu_cluster.sv
// --------------------------------------------------
// ALU cluster top: dispatcher, parallel lanes and an
// in-order collector behind plain valid/ready ports
// --------------------------------------------------
`timescale 1ns/1ps
`include "alu_config.svh"

module alu_cluster import alu_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    // request channel
    input  logic       req_valid,
    output logic       req_ready,
    input  alu_op_t    req_op,
    input  alu_width_t req_width,
    input  alu_data_t  req_a,
    input  alu_data_t  req_b,
    input  logic       req_carry,
    // response channel
    output logic       rsp_valid,
    input  logic       rsp_ready,
    output alu_data_t  rsp_data,
    output alu_flags_t rsp_flags
);

    alu_req_t req;
    alu_rsp_t rsp;

    lane_if lanes [`ALU_LANES] ();

    assign req.op    = req_op;
    assign req.width = req_width;
    assign req.a     = req_a;
    assign req.b     = req_b;
    assign req.carry = req_carry;  // carry-in rides with each request

    assign rsp_data  = rsp.data;
    assign rsp_flags = rsp.flags;

    alu_dispatch u_dispatch (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .lanes     (lanes)
    );

    for (genvar i = 0; i < `ALU_LANES; i++) begin : g_lane
        alu_lane u_lane (
            .clk  (clk),
            .rst  (rst),
            .port (lanes[i])
        );
    end

    alu_collect u_collect (
        .clk       (clk),
        .rst       (rst),
        .lanes     (lanes),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp)
    );

endmodule

// File: verif/alu_cluster_tb.sv
// --------------------------------------------------
// testbench of the ALU cluster: feeds a table of
// requests and checks ordered responses under random stalls
// --------------------------------------------------
`timescale 1ns/1ps

module alu_cluster_tb import alu_pkg::*; ();

    typedef struct {
        alu_op_t    op;
        alu_width_t width;
        alu_data_t  a;
        alu_data_t  b;
        logic       carry;
        alu_data_t  data;
        alu_flags_t flags;
    } vec_t;

    logic       clk = 1'b0;
    logic       rst;
    logic       req_valid;
    logic       req_ready;
    alu_op_t    req_op;
    alu_width_t req_width;
    alu_data_t  req_a;
    alu_data_t  req_b;
    logic       req_carry;
    logic       rsp_valid;
    logic       rsp_ready;
    alu_data_t  rsp_data;
    alu_flags_t rsp_flags;

    vec_t        vecs [$];
    integer      seed;
    logic [31:0] rnd;
    int          cycles = 0;

    alu_cluster dut0 (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_op    (req_op),
        .req_width (req_width),
        .req_a     (req_a),
        .req_b     (req_b),
        .req_carry (req_carry),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_data  (rsp_data),
        .rsp_flags (rsp_flags)
    );

    always #2 clk = ~clk;

    // run limit grows with the table
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > vecs.size() * 20 + 50) begin
            $display("timeout: responses stopped arriving after %0d cycles", cycles);
            $display("Some tests failed");
            $fatal(1, "simulation timed out");
        end
    end

    task automatic check_data(alu_data_t got, alu_data_t exp, string what);
        if (got !== exp) begin
            $display("ERR %0t: %s data %h, expected %h", $time, what, got, exp);
            $display("Some tests failed");
            $fatal(1, "data mismatch");
        end
    endtask

    task automatic check_flags(alu_flags_t got, alu_flags_t exp, string what);
        if (got !== exp) begin
            $display("ERR %0t: %s flags szhvnc %b, expected %b", $time, what, got, exp);
            $display("Some tests failed");
            $fatal(1, "flag mismatch");
        end
    endtask

    task automatic check_bit(logic got, logic exp, string what);
        if (got !== exp) begin
            $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
            $display("Some tests failed");
            $fatal(1, "control mismatch");
        end
    endtask

    function automatic void add_vec(alu_op_t op, alu_width_t w, alu_data_t a, alu_data_t b,
                                    logic cin, alu_data_t data, alu_flags_t flags);
        vec_t v;
        v.op    = op;
        v.width = w;
        v.a     = a;
        v.b     = b;
        v.carry = cin;
        v.data  = data;
        v.flags = flags;
        vecs.push_back(v);
    endfunction

    // columns: op, width, a, b, carry-in, expected data, expected flags s z h v n c
    function automatic void build_table();
        add_vec(OP_ADD, W8,  32'h0000_003a, 32'h0000_00c6, 1'b0, 32'h0000_0000, 6'b011001);
        add_vec(OP_ADD, W8,  32'h0000_007f, 32'h0000_0001, 1'b0, 32'h0000_0080, 6'b101100);
        add_vec(OP_ADC, W8,  32'h0000_000f, 32'h0000_0010, 1'b1, 32'h0000_0020, 6'b001000);
        add_vec(OP_ADD, W16, 32'h0000_1234, 32'h0000_4321, 1'b1, 32'h0000_5555, 6'b000000);
        add_vec(OP_ADC, W16, 32'h0000_ffff, 32'h0000_0000, 1'b1, 32'h0000_0000, 6'b011001);
        add_vec(OP_ADD, W16, 32'habcd_8000, 32'h0000_8000, 1'b0, 32'h0000_0000, 6'b010101);
        add_vec(OP_ADD, W32, 32'h7fff_ffff, 32'h0000_0001, 1'b0, 32'h8000_0000, 6'b101100);
        add_vec(OP_ADC, W32, 32'hffff_ffff, 32'hffff_ffff, 1'b1, 32'hffff_ffff, 6'b101001);
        add_vec(OP_SUB, W8,  32'h0000_0010, 32'h0000_0001, 1'b0, 32'h0000_000f, 6'b001010);
        add_vec(OP_SUB, W8,  32'h0000_0080, 32'h0000_0001, 1'b0, 32'h0000_007f, 6'b001110);
        add_vec(OP_SBC, W8,  32'h0000_0000, 32'h0000_0000, 1'b1, 32'h0000_00ff, 6'b101011);
        add_vec(OP_SBC, W16, 32'h0000_5000, 32'h0000_1000, 1'b1, 32'h0000_3fff, 6'b001010);
        add_vec(OP_SUB, W32, 32'h1234_5678, 32'h1234_5678, 1'b0, 32'h0000_0000, 6'b010010);
        add_vec(OP_SUB, W32, 32'h0000_0001, 32'h0000_0002, 1'b0, 32'hffff_ffff, 6'b101011);
        add_vec(OP_CP,  W8,  32'h0000_1142, 32'h0000_0050, 1'b0, 32'h0000_0042, 6'b100011);
        add_vec(OP_CP,  W16, 32'h0000_8000, 32'h0000_8000, 1'b0, 32'h0000_8000, 6'b010010);
        add_vec(OP_NEG, W8,  32'h0000_0001, 32'h0000_0000, 1'b0, 32'h0000_00ff, 6'b101011);
        add_vec(OP_NEG, W8,  32'h0000_0080, 32'h0000_0000, 1'b0, 32'h0000_0080, 6'b100111);
        add_vec(OP_NEG, W32, 32'h0000_0000, 32'h0000_0000, 1'b0, 32'h0000_0000, 6'b010010);
        add_vec(OP_AND, W8,  32'h0000_00f0, 32'h0000_003c, 1'b0, 32'h0000_0030, 6'b001100);
        add_vec(OP_AND, W16, 32'h0000_0f0f, 32'h0000_f0f0, 1'b0, 32'h0000_0000, 6'b011100);
        add_vec(OP_OR,  W8,  32'h0000_0080, 32'h0000_0001, 1'b0, 32'h0000_0081, 6'b100100);
        add_vec(OP_OR,  W32, 32'h8000_0000, 32'h0000_0007, 1'b0, 32'h8000_0007, 6'b100000);
        add_vec(OP_XOR, W16, 32'h0000_ffff, 32'h0000_00fe, 1'b0, 32'h0000_ff01, 6'b100000);
        add_vec(OP_XOR, W32, 32'h1234_5678, 32'h1234_5678, 1'b0, 32'h0000_0000, 6'b010100);
        add_vec(OP_XOR, W8,  32'h0000_01ff, 32'h0000_0000, 1'b0, 32'h0000_00ff, 6'b100100);
        // shifts, count in b[3:0] and 0 stands for 16
        add_vec(OP_RL,  W8,  32'h0000_0081, 32'h0000_0001, 1'b0, 32'h0000_0002, 6'b000001);
        add_vec(OP_RL,  W8,  32'h0000_0081, 32'h0000_0003, 1'b1, 32'h0000_000e, 6'b000000);
        add_vec(OP_RR,  W16, 32'h0000_8001, 32'h0000_0010, 1'b1, 32'h0000_0003, 6'b000101);
        add_vec(OP_RR,  W32, 32'h0000_0002, 32'h0000_0003, 1'b1, 32'ha000_0000, 6'b100100);
        add_vec(OP_RLC, W8,  32'h0000_0081, 32'h0000_0001, 1'b0, 32'h0000_0003, 6'b000101);
        add_vec(OP_RLC, W16, 32'h0000_e000, 32'h0000_0003, 1'b0, 32'h0000_0007, 6'b000001);
        add_vec(OP_RLC, W32, 32'h8000_0001, 32'h0000_0000, 1'b0, 32'h0001_8000, 6'b000000);
        add_vec(OP_RRC, W16, 32'h0000_0005, 32'h0000_0003, 1'b0, 32'h0000_a000, 6'b100101);
        add_vec(OP_RRC, W8,  32'h0000_000f, 32'h0000_0000, 1'b0, 32'h0000_000f, 6'b000100);
        add_vec(OP_SLA, W16, 32'h0000_4001, 32'h0000_0001, 1'b0, 32'h0000_8002, 6'b100100);
        add_vec(OP_SLA, W8,  32'h0000_00ff, 32'h0000_0000, 1'b0, 32'h0000_0000, 6'b010100);
        add_vec(OP_SLL, W32, 32'h3000_0001, 32'h0000_0003, 1'b0, 32'h8000_0008, 6'b100001);
        add_vec(OP_SLL, W8,  32'h0000_0081, 32'h0000_0001, 1'b0, 32'h0000_0002, 6'b000001);
        add_vec(OP_SRA, W8,  32'h0000_0084, 32'h0000_0003, 1'b0, 32'h0000_00f0, 6'b100101);
        add_vec(OP_SRA, W16, 32'h0000_8000, 32'h0000_0000, 1'b0, 32'h0000_ffff, 6'b100101);
        add_vec(OP_SRA, W32, 32'h8000_0001, 32'h0000_0001, 1'b0, 32'hc000_0000, 6'b100101);
        add_vec(OP_SRL, W32, 32'h0000_0007, 32'h0000_0001, 1'b0, 32'h0000_0003, 6'b000101);
        add_vec(OP_SRL, W16, 32'h1234_8001, 32'h0000_0000, 1'b0, 32'h0000_0000, 6'b010101);
    endfunction

    // back to back, each request held until the cluster takes it
    task automatic send_requests();
        foreach (vecs[i]) begin
            req_valid = 1'b1;
            req_op    = vecs[i].op;
            req_width = vecs[i].width;
            req_a     = vecs[i].a;
            req_b     = vecs[i].b;
            req_carry = vecs[i].carry;
            while (!req_ready) @(negedge clk);
            @(negedge clk);  // taken on the edge just passed
        end
        req_valid = 1'b0;
    endtask

    // table index moves only on a response transfer
    task automatic take_responses();
        int    idx;
        string what;
        idx = 0;
        while (idx < vecs.size()) begin
            @(negedge clk);
            rnd       = $random(seed);
            rsp_ready = (rnd[1:0] != 2'b00);
            if (rsp_valid && rsp_ready) begin
                what = $sformatf("entry %0d %s", idx, vecs[idx].op.name());
                check_data(rsp_data, vecs[idx].data, what);
                check_flags(rsp_flags, vecs[idx].flags, what);
                idx++;
            end
        end
        @(negedge clk);
        rsp_ready = 1'b0;
    endtask

    initial begin
        seed      = 32'hcd930b82;
        rst       = 1'b1;
        req_valid = 1'b0;
        req_op    = OP_ADD;
        req_width = W8;
        req_a     = '0;
        req_b     = '0;
        req_carry = 1'b0;
        rsp_ready = 1'b0;
        build_table();
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_bit(rsp_valid, 1'b0, "rsp_valid after reset");
        check_bit(req_ready, 1'b1, "req_ready after reset");
        fork
            send_requests();
            take_responses();
        join
        repeat (4) @(negedge clk);
        check_bit(rsp_valid, 1'b0, "rsp_valid once drained");  // nothing extra comes out
        check_bit(req_ready, 1'b1, "req_ready once drained");
        $display("All tests passed");
        $finish;
    end

endmodule

// File: list.f
+incdir+logic
logic/alu_pkg.sv
logic/lane_if.sv
logic/alu_dispatch.sv
logic/alu_lane.sv
logic/alu_collect.sv
logic/alu_cluster.sv
verif/alu_cluster_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build the ALU cluster testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module alu_cluster_tb \
    -f list.f -o sim_alu_cluster || { echo "build failed"; exit 1; }
out="$(./obj_dir/sim_alu_cluster 2>&1)"
echo "$out"
echo "$out" | grep -q "All tests passed" && exit 0 || exit 1
